//--- Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/cpu_decode.sv
      - rtl/cpu_registers.sv
      - rtl/cpu_execute.sv
      - rtl/cpu_core.sv
  - target: test
    files:
      - verification/cpu_core_asserts.sv
      - verification/cpu_core_tb.sv

//--- build.f
rtl/cpu_pkg.sv
rtl/cpu_decode.sv
rtl/cpu_registers.sv
rtl/cpu_execute.sv
rtl/cpu_core.sv
verification/cpu_core_asserts.sv
verification/cpu_core_tb.sv

//--- rtl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
	parameter logic [31:0] STACK_POINTER = 32'h0000_1000
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_inst_valid,
	input  logic [31:0] i_inst,
	output logic        o_retire_valid,
	output logic [4:0]  o_retire_rd,
	output logic [31:0] o_retire_value
);
	import cpu_pkg::*;

	fetch_data_t  fetch_data;
	memory_data_t memory_data;
	logic [31:0]  rs1;
	logic [31:0]  rs2;

	cpu_decode u_decode (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.o_fetch_data (fetch_data)
	);

	// The register file also sees the result record coming back from execute.
	cpu_registers #(
		.STACK_POINTER (STACK_POINTER)
	) u_registers (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_fetch_data  (fetch_data),
		.i_memory_data (memory_data),
		.o_rs1         (rs1),
		.o_rs2         (rs2)
	);

	cpu_execute u_execute (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_fetch_data   (fetch_data),
		.i_rs1          (rs1),
		.i_rs2          (rs2),
		.o_memory_data  (memory_data),
		.o_retire_valid (o_retire_valid),
		.o_retire_rd    (o_retire_rd),
		.o_retire_value (o_retire_value)
	);

endmodule

//--- rtl/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_inst_valid,
	input  logic [31:0]          i_inst,
	output cpu_pkg::fetch_data_t o_fetch_data
);
	import cpu_pkg::*;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [31:0] imm_i;
	logic [31:0] imm_u;
	fetch_data_t decoded;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign imm_i  = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_u  = {i_inst[31:12], 12'h000};

	// Shared by OP and OP-IMM; alt is the funct7 bit 30 where it matters.
	function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		decoded          = '0;
		decoded.valid    = 1'b1;
		decoded.inst_rs1 = i_inst[19:15];
		decoded.inst_rs2 = i_inst[24:20];
		decoded.inst_rd  = i_inst[11:7];
		decoded.alu_op   = ALU_NONE;
		case (opcode)
			OPCODE_OP: begin
				decoded.alu_op = alu_from_funct3(funct3, i_inst[30]);
			end
			OPCODE_OP_IMM: begin
				decoded.use_imm = 1'b1;
				// ADDI has no SUB form, only the right shift looks at bit 30.
				decoded.alu_op = alu_from_funct3(funct3, (funct3 == 3'b101) && i_inst[30]);
				if (funct3 == 3'b001 || funct3 == 3'b101)
					decoded.imm = {27'd0, i_inst[24:20]}; // Shift amount only.
				else
					decoded.imm = imm_i;
			end
			OPCODE_LUI: begin
				decoded.use_imm  = 1'b1;
				decoded.alu_op   = ALU_PASS;
				decoded.inst_rs1 = 5'd0;
				decoded.inst_rs2 = 5'd0;
				decoded.imm      = imm_u;
			end
			default: begin
				decoded.inst_rd = 5'd0; // Unknown opcodes must not write.
			end
		endcase
	end

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset)
			o_fetch_data <= '0;
		else if (i_inst_valid)
			o_fetch_data <= decoded;
		else
			o_fetch_data.valid <= 1'b0; // Other fields keep the last instruction.
	end

endmodule

//--- rtl/cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  cpu_pkg::fetch_data_t  i_fetch_data,
	input  logic [31:0]           i_rs1,
	input  logic [31:0]           i_rs2,
	output cpu_pkg::memory_data_t o_memory_data,
	output logic                  o_retire_valid,
	output logic [4:0]            o_retire_rd,
	output logic [31:0]           o_retire_value
);
	import cpu_pkg::*;

	fetch_data_t fetch_q; // Lines up with the registered operands.
	logic [31:0] operand_a;
	logic [31:0] operand_b;
	logic [4:0]  shamt;
	logic [31:0] result;

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset)
			fetch_q <= '0;
		else
			fetch_q <= i_fetch_data;
	end

	assign operand_a = i_rs1;
	assign operand_b = fetch_q.use_imm ? fetch_q.imm : i_rs2;
	assign shamt     = operand_b[4:0];

	always_comb begin
		case (fetch_q.alu_op)
			ALU_ADD:  result = operand_a + operand_b;
			ALU_SUB:  result = operand_a - operand_b;
			ALU_SLL:  result = operand_a << shamt;
			ALU_SLT:  result = {31'd0, $signed(operand_a) < $signed(operand_b)};
			ALU_SLTU: result = {31'd0, operand_a < operand_b};
			ALU_XOR:  result = operand_a ^ operand_b;
			ALU_SRL:  result = operand_a >> shamt;
			ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt);
			ALU_OR:   result = operand_a | operand_b;
			ALU_AND:  result = operand_a & operand_b;
			ALU_PASS: result = operand_b;
			default:  result = 32'h0000_0000;
		endcase
	end

	// Every valid instruction retires, and each retirement flips the tag once,
	// which is what makes the register file take the write.
	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_memory_data  <= '0;
			o_retire_valid <= 1'b0;
		end
		else begin
			o_retire_valid <= fetch_q.valid;
			if (fetch_q.valid) begin
				o_memory_data.tag     <= o_memory_data.tag + TAG_WIDTH'(1);
				o_memory_data.inst_rd <= fetch_q.inst_rd;
				o_memory_data.rd      <= result;
			end
		end
	end

	// Retirement report holds until the next retirement, like the record.
	assign o_retire_rd    = o_memory_data.inst_rd;
	assign o_retire_value = o_memory_data.rd;

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

	// One bit is enough, since the register file only looks for a change.
	localparam int TAG_WIDTH = 1;

	// Major opcodes handled by this datapath slice.
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS, // Second operand straight through, used by LUI.
		ALU_NONE  // Undecoded instruction, retires with no effect.
	} alu_op_e;

	// Decoded instruction, produced by decode and consumed by the register
	// file (indices only) and by execute.
	typedef struct packed {
		logic        valid;
		logic [4:0]  inst_rs1;
		logic [4:0]  inst_rs2;
		logic [4:0]  inst_rd;
		logic        use_imm;
		alu_op_e     alu_op;
		logic [31:0] imm;
	} fetch_data_t;

	// Result record going back to the register file.
	// A write is signalled by a change of tag, not by a valid bit.
	typedef struct packed {
		logic [TAG_WIDTH-1:0] tag;
		logic [4:0]           inst_rd;
		logic [31:0]          rd;
	} memory_data_t;

endpackage

//--- rtl/cpu_registers.sv
`timescale 1ns/1ps

module cpu_registers #(
	parameter logic [31:0] STACK_POINTER = 32'h0000_1000
) (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  cpu_pkg::fetch_data_t  i_fetch_data,
	input  cpu_pkg::memory_data_t i_memory_data,
	output logic [31:0]           o_rs1,
	output logic [31:0]           o_rs2
);
	import cpu_pkg::*;

	logic [31:0]          r [32];
	logic [TAG_WIDTH-1:0] write_tag; // Tag of the last accepted write.
	logic                 write_en;

	// A new result is present when its tag differs from the one last seen.
	assign write_en = (i_memory_data.tag != write_tag);

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_rs1     <= '0;
			o_rs2     <= '0;
			write_tag <= '0;
			for (int i = 0; i < 32; i++)
				r[i] <= (i == 2) ? STACK_POINTER : 32'h0000_0000;
		end
		else begin
			// Reads see the array before this cycle's write.
			o_rs1 <= (i_fetch_data.inst_rs1 != 5'd0) ? r[i_fetch_data.inst_rs1] : 32'h0;
			o_rs2 <= (i_fetch_data.inst_rs2 != 5'd0) ? r[i_fetch_data.inst_rs2] : 32'h0;

			if (write_en) begin
				if (|i_memory_data.inst_rd)
					r[i_memory_data.inst_rd] <= i_memory_data.rd; // x0 stays zero.
				write_tag <= i_memory_data.tag;
			end
		end
	end

endmodule

//--- verification/cpu_core_asserts.sv
`timescale 1ns/1ps

module cpu_core_asserts (
	input logic                          i_clock,
	input logic                          i_reset,
	input logic                          i_inst_valid,
	input logic                          i_fetch_valid,
	input logic                          i_retire_valid,
	input logic [cpu_pkg::TAG_WIDTH-1:0] i_tag
);

	// Back to back retirements need back to back decoded records two cycles earlier.
	a_back_to_back: assert property (@(posedge i_clock) disable iff (i_reset)
		i_retire_valid && $past(i_retire_valid)
			|-> $past(i_fetch_valid, 2) && $past(i_fetch_valid, 3))
		else $error("Consecutive retirements without matching decoded instructions.");

	a_issue_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		i_inst_valid |-> ##3 i_retire_valid)
		else $error("An issued instruction did not retire three cycles later.");

	// The register file writes on a tag change, so the tag must move with a retirement.
	a_tag_change: assert property (@(posedge i_clock) disable iff (i_reset)
		$changed(i_tag) |-> i_retire_valid)
		else $error("The memory record tag changed without a retirement.");

	a_reset_quiet: assert property (@(posedge i_clock)
		i_reset |-> !i_retire_valid)
		else $error("Retirement pulse seen during reset.");

endmodule

bind cpu_core cpu_core_asserts u_asserts (
	.i_clock        (i_clock),
	.i_reset        (i_reset),
	.i_inst_valid   (i_inst_valid),
	.i_fetch_valid  (fetch_data.valid),
	.i_retire_valid (o_retire_valid),
	.i_tag          (memory_data.tag)
);

//--- verification/cpu_core_patterns.txt
# Columns: name, instruction word (hex), idle cycles after issue (decimal),
# expected rd (decimal), expected result (hex). Lines starting with # are skipped.
addi_x5_x2_0       00010293 0 5  00001000
add_x6_x1_x0       00008333 0 6  00000000
lui_x1_12345       123450b7 2 1  12345000
addi_x1_x1_678     67808093 2 1  12345678
addi_x3_x0_m8      ff800193 0 3  fffffff8
addi_x4_x0_35      02300213 2 4  00000023
slti_x10_x3_5      0051a513 0 10 00000001
sltiu_x11_x3_5     0051b593 0 11 00000000
xori_x12_x1_m1     fff0c613 0 12 edcba987
ori_x13_x1_f0      0f00e693 0 13 123456f8
andi_x14_x1_ff     0ff0f713 0 14 00000078
slli_x15_x1_4      00409793 0 15 23456780
srli_x16_x3_4      0041d813 0 16 0fffffff
srai_x17_x3_4      4041d893 0 17 ffffffff
addi_x18_x2_m16    ff010913 0 18 00000ff0
add_x20_x1_x3      00308a33 0 20 12345670
sub_x21_x2_x1      40110ab3 0 21 edcbb988
sll_x22_x1_x4      00409b33 0 22 91a2b3c0
slt_x23_x3_x1      0011abb3 0 23 00000001
sltu_x24_x3_x1     0011bc33 0 24 00000000
xor_x25_x1_x3      0030ccb3 0 25 edcba980
srl_x26_x3_x4      0041dd33 0 26 1fffffff
sra_x27_x3_x4      4041ddb3 0 27 ffffffff
or_x28_x2_x4       00416e33 0 28 00001023
and_x29_x1_x2      0020feb3 0 29 00001000
addi_x0_x1_1       00108013 2 0  12345679
add_x30_x0_x2      00200f33 0 30 00001000
addi_x7_x0_100     06400393 2 7  00000064
add_x8_x7_x7       00738433 0 8  000000c8
lui_x9_deadb       deadb4b7 2 9  deadb000
addi_x9_x9_m111    eef48493 0 9  deadaeef
undecoded_word     ffffffff 0 0  00000000

//--- verification/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;
	import cpu_pkg::*;

	localparam logic [31:0] STACK_POINTER = 32'h0000_1000;
	localparam int RETIRE_TIMEOUT = 20;

	logic        i_clock;
	logic        i_reset;
	logic        i_inst_valid;
	logic [31:0] i_inst;
	logic        o_retire_valid;
	logic [4:0]  o_retire_rd;
	logic [31:0] o_retire_value;

	string       names[$];
	logic [31:0] insts[$];
	int          gaps[$];
	logic [4:0]  exp_rd[$];
	logic [31:0] exp_value[$];

	cpu_core #(
		.STACK_POINTER (STACK_POINTER)
	) uut (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_inst_valid   (i_inst_valid),
		.i_inst         (i_inst),
		.o_retire_valid (o_retire_valid),
		.o_retire_rd    (o_retire_rd),
		.o_retire_value (o_retire_value)
	);

	initial i_clock = 1'b0;
	always #2 i_clock = ~i_clock;

	task automatic stop_on_failure();
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
			stop_on_failure();
		end
	endtask

	function automatic string opcode_name(input logic [31:0] inst);
		case (inst[6:0])
			OPCODE_OP:     return "OP";
			OPCODE_OP_IMM: return "OP-IMM";
			OPCODE_LUI:    return "LUI";
			default:       return "unknown opcode";
		endcase
	endfunction

	task automatic load_patterns();
		int          fd;
		int          count;
		int          gap;
		int          rd;
		string       line;
		string       name;
		logic [31:0] inst;
		logic [31:0] value;
		fd = $fopen("verification/cpu_core_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open verification/cpu_core_patterns.txt.");
			stop_on_failure();
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue; // Column header or blank line.
			count = $sscanf(line, "%s %h %d %d %h", name, inst, gap, rd, value);
			if (count == 5) begin
				names.push_back(name);
				insts.push_back(inst);
				gaps.push_back(gap);
				exp_rd.push_back(rd[4:0]);
				exp_value.push_back(value);
			end
		end
		$fclose(fd);
		if (names.size() == 0) begin
			$display("The pattern file holds no instructions.");
			stop_on_failure();
		end
	endtask

	// One strobe per instruction, then the idle gap from the pattern line.
	task automatic drive_instructions();
		for (int i = 0; i < insts.size(); i++) begin
			i_inst_valid = 1'b1;
			i_inst       = insts[i];
			@(negedge i_clock);
			i_inst_valid = 1'b0;
			repeat (gaps[i]) @(negedge i_clock);
		end
	endtask

	task automatic check_retirements();
		int    waited;
		string test;
		for (int i = 0; i < names.size(); i++) begin
			waited = 0;
			@(negedge i_clock);
			while (!o_retire_valid) begin
				waited++;
				if (waited > RETIRE_TIMEOUT) begin
					$display("Instruction %0d (%s) never retired within %0d cycles.",
						i, names[i], RETIRE_TIMEOUT);
					stop_on_failure();
				end
				@(negedge i_clock);
			end
			test = $sformatf("%s %s", opcode_name(insts[i]), names[i]);
			check_value({test, " rd"}, {27'd0, exp_rd[i]}, {27'd0, o_retire_rd});
			check_value({test, " value"}, exp_value[i], o_retire_value);
		end
	endtask

	// Nothing may retire once the pattern list is used up.
	task automatic check_idle();
		for (int i = 0; i < 10; i++) begin
			@(negedge i_clock);
			if (o_retire_valid) begin
				$display("An extra instruction retired after the last pattern line.");
				stop_on_failure();
			end
		end
	endtask

	initial begin
		i_reset      = 1'b1;
		i_inst_valid = 1'b0;
		i_inst       = 32'h0000_0000;
		load_patterns();
		repeat (10) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		@(negedge i_clock);
		fork
			drive_instructions();
			check_retirements();
		join
		check_idle();
		$display("STATUS: PASS");
		$finish;
	end

endmodule
